// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;

    // bit 3 set means no destination register
    typedef logic [3:0] reg_sel_t;

    localparam logic [4:0] op_halt  = 5'b00000;
    localparam logic [4:0] op_nop   = 5'b00001;
    localparam logic [4:0] op_addi  = 5'b01000;
    localparam logic [4:0] op_xori  = 5'b01010;
    localparam logic [4:0] op_alu_r = 5'b11011;

    localparam logic [1:0] fn_add  = 2'b00;
    localparam logic [1:0] fn_sub  = 2'b01;
    localparam logic [1:0] fn_xor  = 2'b10;
    localparam logic [1:0] fn_andn = 2'b11;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_andn
    } alu_op_t;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } i_fmt_t;

    // two field layouts over the same 16 bits
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_t;

    localparam word_t    nop_instr   = 16'h0800;
    localparam word_t    bubble_pc   = 16'hffff;
    localparam reg_sel_t reg_invalid = 4'b1111;

endpackage

`default_nettype wire

// ==== logic/de_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

interface de_bus;
    import cpu_pkg::*;

    word_t    pc;
    word_t    instr;
    word_t    read1_data;
    word_t    read2_data;
    word_t    imm_ext;
    alu_op_t  alu_op;
    logic     alu_src;
    logic     reg_write;
    reg_sel_t write_sel;
    logic     halt;

    modport src (
        output pc, instr, read1_data, read2_data, imm_ext,
        output alu_op, alu_src, reg_write, write_sel, halt
    );

    modport dst (
        input pc, instr, read1_data, read2_data, imm_ext,
        input alu_op, alu_src, reg_write, write_sel, halt
    );

endinterface

`default_nettype wire

// ==== logic/instruction_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder (
    input  cpu_pkg::instr_word_t instr,
    input  cpu_pkg::word_t       pc,
    input  cpu_pkg::reg_sel_t    write_sel_e,
    input  logic                 reg_write_e,
    output logic [2:0]           rs_sel,
    output logic [2:0]           rt_sel,
    de_bus.src                   de,
    output logic                 stall
);
    import cpu_pkg::*;

    logic uses_rs;
    logic uses_rt;
    logic rs_hit;
    logic rt_hit;

    // rs sits at the same bits in both views
    assign rs_sel = instr.r.rs;
    assign rt_sel = instr.r.rt;

    assign de.pc      = pc;
    assign de.instr   = instr;
    assign de.imm_ext = {{11{instr.i.imm[4]}}, instr.i.imm};

    always_comb begin
        uses_rs      = 1'b0;
        uses_rt      = 1'b0;
        de.alu_op    = alu_add;
        de.alu_src   = 1'b0;
        de.reg_write = 1'b0;
        de.write_sel = reg_invalid;
        de.halt      = 1'b0;

        case (instr.r.opcode)
            op_alu_r: begin
                uses_rs      = 1'b1;
                uses_rt      = 1'b1;
                de.reg_write = 1'b1;
                de.write_sel = {1'b0, instr.r.rd};
                case (instr.r.funct)
                    fn_add:  de.alu_op = alu_add;
                    fn_sub:  de.alu_op = alu_sub;
                    fn_xor:  de.alu_op = alu_xor;
                    fn_andn: de.alu_op = alu_andn;
                    default: de.alu_op = alu_add;
                endcase
            end
            op_addi: begin
                uses_rs      = 1'b1;
                de.alu_src   = 1'b1;
                de.reg_write = 1'b1;
                de.write_sel = {1'b0, instr.i.rd};
                de.alu_op    = alu_add;
            end
            op_xori: begin
                uses_rs      = 1'b1;
                de.alu_src   = 1'b1;
                de.reg_write = 1'b1;
                de.write_sel = {1'b0, instr.i.rd};
                de.alu_op    = alu_xor;
            end
            op_halt: begin
                de.halt = 1'b1;
            end
            // nop and unknown opcodes do nothing
            default: begin
                de.halt = 1'b0;
            end
        endcase
    end

    // invalid select has bit 3 set, so an empty slot never matches
    assign rs_hit = uses_rs && ({1'b0, rs_sel} == write_sel_e);
    assign rt_hit = uses_rt && ({1'b0, rt_sel} == write_sel_e);
    assign stall  = reg_write_e && (rs_hit || rt_hit);

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic [2:0]        rs_sel,
    input  logic [2:0]        rt_sel,
    output cpu_pkg::word_t    read1_data,
    output cpu_pkg::word_t    read2_data,
    input  logic              write_en,
    input  cpu_pkg::reg_sel_t write_sel,
    input  cpu_pkg::word_t    write_data
);
    import cpu_pkg::*;

    word_t regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && !write_sel[3]) begin
            regs[write_sel[2:0]] <= write_data;
        end
    end

    // bypass so decode sees the value retiring this cycle
    assign read1_data = (write_en && write_sel == {1'b0, rs_sel}) ? write_data : regs[rs_sel];
    assign read2_data = (write_en && write_sel == {1'b0, rt_sel}) ? write_data : regs[rt_sel];

endmodule

`default_nettype wire

// ==== logic/decode_execute_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_execute_latch (
    input  logic clk,
    input  logic rst,
    input  logic nop,
    de_bus.dst   d,
    de_bus.src   e
);
    import cpu_pkg::*;

    // bubble on reset and on every stall cycle
    always_ff @(posedge clk) begin
        if (rst || nop) begin
            e.pc        <= bubble_pc;
            e.instr     <= nop_instr;
            e.alu_op    <= alu_add;
            e.alu_src   <= 1'b0;
            e.reg_write <= 1'b0;
            e.write_sel <= reg_invalid;
            e.halt      <= 1'b0;
        end else begin
            e.pc        <= d.pc;
            e.instr     <= d.instr;
            e.alu_op    <= d.alu_op;
            e.alu_src   <= d.alu_src;
            e.reg_write <= d.reg_write;
            e.halt      <= d.halt;
            // a fetched nop must not look like a write to r0..r7
            if (d.instr == nop_instr) begin
                e.write_sel <= reg_invalid;
            end else begin
                e.write_sel <= d.write_sel;
            end
        end
    end

    // operand data matters only when control uses it
    always_ff @(posedge clk) begin
        e.read1_data <= d.read1_data;
        e.read2_data <= d.read2_data;
        e.imm_ext    <= d.imm_ext;
    end

endmodule

`default_nettype wire

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  logic              clk,
    input  logic              rst,
    de_bus.dst                e,
    output cpu_pkg::reg_sel_t write_sel_e,
    output logic              reg_write_e,
    output logic              wb_valid,
    output cpu_pkg::reg_sel_t wb_sel,
    output cpu_pkg::word_t    wb_data,
    output logic              halted
);
    import cpu_pkg::*;

    word_t operand_b;
    word_t alu_result;
    logic  retire;

    // hazard information back to decode
    assign write_sel_e = e.write_sel;
    assign reg_write_e = e.reg_write;

    assign operand_b = e.alu_src ? e.imm_ext : e.read2_data;

    always_comb begin
        case (e.alu_op)
            alu_add:  alu_result = e.read1_data + operand_b;
            alu_sub:  alu_result = e.read1_data - operand_b;
            alu_xor:  alu_result = e.read1_data ^ operand_b;
            alu_andn: alu_result = e.read1_data & ~operand_b;
            default:  alu_result = e.read1_data;
        endcase
    end

    // nothing retires once the core has halted
    assign retire = e.reg_write && !halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_sel   <= reg_invalid;
            halted   <= 1'b0;
        end else begin
            wb_valid <= retire;
            wb_sel   <= retire ? e.write_sel : reg_invalid;
            if (e.halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= alu_result;
    end

endmodule

`default_nettype wire

// ==== logic/cpu_decode_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_decode_execute (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::word_t    pc_f,
    input  cpu_pkg::word_t    instr_f,
    output logic              stall,
    output logic              wb_valid,
    output cpu_pkg::reg_sel_t wb_sel,
    output cpu_pkg::word_t    wb_data,
    output logic              halted
);
    import cpu_pkg::*;

    logic [2:0] rs_sel;
    logic [2:0] rt_sel;
    reg_sel_t   write_sel_e;
    logic       reg_write_e;

    // decode side and execute side of the pipeline latch
    de_bus de_d ();
    de_bus de_e ();

    instruction_decoder instruction_decoder_inst (
        .instr       (instr_f),
        .pc          (pc_f),
        .write_sel_e (write_sel_e),
        .reg_write_e (reg_write_e),
        .rs_sel      (rs_sel),
        .rt_sel      (rt_sel),
        .de          (de_d),
        .stall       (stall)
    );

    // read data completes the decode bundle
    reg_file reg_file_inst (
        .clk        (clk),
        .rst        (rst),
        .rs_sel     (rs_sel),
        .rt_sel     (rt_sel),
        .read1_data (de_d.read1_data),
        .read2_data (de_d.read2_data),
        .write_en   (wb_valid),
        .write_sel  (wb_sel),
        .write_data (wb_data)
    );

    decode_execute_latch decode_execute_latch_inst (
        .clk (clk),
        .rst (rst),
        .nop (stall),
        .d   (de_d),
        .e   (de_e)
    );

    execute_unit execute_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .e           (de_e),
        .write_sel_e (write_sel_e),
        .reg_write_e (reg_write_e),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data),
        .halted      (halted)
    );

endmodule

`default_nettype wire

// ==== sim/cpu_decode_execute_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_decode_execute_properties (
    input logic              clk,
    input logic              rst,
    input logic              stall,
    input cpu_pkg::reg_sel_t write_sel_e,
    input logic              wb_valid,
    input logic              halted
);
    import cpu_pkg::*;

    // the bubble clears the hazard, so decode moves on next cycle
    stall_single: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
        else $error("stall held for more than one cycle");

    // a stall cycle leaves an empty slot in the latch
    bubble_invalid: assert property (@(posedge clk) disable iff (rst)
        stall |=> write_sel_e == reg_invalid)
        else $error("latch holds a register select after a stall cycle");

    wb_quiet_in_reset: assert property (@(posedge clk) rst |=> !wb_valid)
        else $error("writeback during reset");

    no_wb_after_halt: assert property (@(posedge clk) disable iff (rst) halted |-> !wb_valid)
        else $error("writeback after halt");

endmodule

bind cpu_decode_execute cpu_decode_execute_properties cpu_decode_execute_properties_inst (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .write_sel_e (write_sel_e),
    .wb_valid    (wb_valid),
    .halted      (halted)
);

`default_nettype wire

// ==== sim/cpu_decode_execute_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_decode_execute_tb;
    import cpu_pkg::*;

    typedef struct {
        reg_sel_t sel;
        word_t    data;
        int       due;
    } wb_exp_t;

    localparam int reset_cycles = 16;
    // 7 + 5 + 7 + 60 + 4 instructions over all tests
    localparam int total_instr  = 83;
    localparam int limit_ns     = (total_instr * 4 + reset_cycles) * 4;

    logic        clk = 1'b0;
    logic        rst;
    word_t       pc_f;
    word_t       instr_f;
    logic        stall;
    logic        wb_valid;
    reg_sel_t    wb_sel;
    word_t       wb_data;
    logic        halted;

    word_t       model_regs [8];
    wb_exp_t     exp_q [$];
    logic [31:0] lcg_state = 32'hb6bc;
    int          cycle = 0;
    int          last_accept = -10;
    int          last_dest = -1;
    int          halt_due = -1;

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    cpu_decode_execute cpu_decode_execute_inst (
        .clk      (clk),
        .rst      (rst),
        .pc_f     (pc_f),
        .instr_f  (instr_f),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .halted   (halted)
    );

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic word_t r_word(input logic [1:0] fn, input int rd, input int rs,
                                     input int rt);
        return {op_alu_r, rs[2:0], rt[2:0], rd[2:0], fn};
    endfunction

    function automatic word_t i_word(input logic [4:0] op, input int rd, input int rs,
                                     input logic [4:0] imm);
        return {op, rs[2:0], rd[2:0], imm};
    endfunction

    // true when the word uses register r as a source
    function automatic logic reads_reg(input word_t w, input int r);
        if (r < 0) return 1'b0;
        if (w[15:11] == op_alu_r) return (w[10:8] == r) || (w[7:5] == r);
        if (w[15:11] == op_addi || w[15:11] == op_xori) return w[10:8] == r;
        return 1'b0;
    endfunction

    // architectural effect of each accepted word in program order
    task automatic retire_model(input word_t w);
        logic [4:0] op;
        logic [1:0] fn;
        logic [2:0] rd;
        word_t      a;
        word_t      b;
        word_t      res;
        op = w[15:11];
        fn = (op == op_alu_r) ? w[1:0] : ((op == op_xori) ? fn_xor : fn_add);
        rd = (op == op_alu_r) ? w[4:2] : w[7:5];
        a  = model_regs[w[10:8]];
        b  = (op == op_alu_r) ? model_regs[w[7:5]] : {{11{w[4]}}, w[4:0]};
        case (fn)
            fn_add:  res = a + b;
            fn_sub:  res = a - b;
            fn_xor:  res = a ^ b;
            default: res = a & ~b;
        endcase
        last_accept = cycle;
        last_dest   = -1;
        if (op == op_halt && halt_due < 0) begin
            halt_due = cycle + 2;
        end
        if (op == op_alu_r || op == op_addi || op == op_xori) begin
            last_dest = rd;
            // after halt the word still flows, but retires nothing
            if (halt_due < 0) begin
                model_regs[rd] = res;
                exp_q.push_back('{{1'b0, rd}, res, cycle + 2});
            end
        end
    endtask

    // runs from one drive point to the next
    task automatic issue(input word_t w);
        int   stalls;
        logic exp_stall;
        stalls  = 0;
        instr_f = w;
        @(negedge clk);
        exp_stall = (last_accept == cycle - 1) && reads_reg(w, last_dest);
        while (stall) begin
            stalls++;
            @(negedge clk);
        end
        assert (stalls == (exp_stall ? 1 : 0))
            else report_fail($sformatf("%0d stall cycles for word %h", stalls, w));
        retire_model(w);
        @(posedge clk);
        #1;
        instr_f = nop_instr;
        pc_f    = pc_f + 16'd2;
    endtask

    task automatic drain();
        while (exp_q.size() > 0) @(negedge clk);
        repeat (3) @(posedge clk);
        #1;
    endtask

    // writeback and halt checker
    always @(negedge clk) begin
        if (!rst) begin
            assert (halted == (halt_due >= 0 && cycle >= halt_due))
                else report_fail($sformatf("halted is %b in cycle %0d", halted, cycle));
            if (wb_valid) begin
                assert (exp_q.size() > 0)
                    else report_fail($sformatf("unexpected writeback to r%0d", wb_sel));
                assert (wb_sel == exp_q[0].sel && wb_data == exp_q[0].data
                        && cycle == exp_q[0].due)
                    else report_fail($sformatf("wb r%0d=%h cycle %0d, expected r%0d=%h cycle %0d",
                        wb_sel, wb_data, cycle, exp_q[0].sel, exp_q[0].data, exp_q[0].due));
                void'(exp_q.pop_front());
            end else begin
                assert (exp_q.size() == 0 || exp_q[0].due > cycle)
                    else report_fail($sformatf("missing writeback to r%0d", exp_q[0].sel));
            end
        end
    end

    task automatic check_reset_state();
        @(negedge clk);
        assert (!stall && !wb_valid && !halted)
            else report_fail("outputs not idle after reset");
        @(posedge clk);
        #1;
    endtask

    task automatic register_ops();
        issue(i_word(op_addi, 1, 0, 5'd7));
        issue(i_word(op_addi, 2, 0, 5'h1d));
        issue(i_word(op_xori, 3, 0, 5'd12));
        issue(r_word(fn_add, 4, 1, 2));
        issue(r_word(fn_sub, 5, 1, 3));
        issue(r_word(fn_xor, 6, 2, 3));
        issue(r_word(fn_andn, 7, 2, 1));
        drain();
    endtask

    task automatic immediate_ops();
        issue(i_word(op_addi, 1, 1, 5'h10));
        issue(i_word(op_addi, 2, 2, 5'h0f));
        issue(i_word(op_xori, 3, 3, 5'h1f));
        issue(i_word(op_xori, 4, 4, 5'd5));
        issue(i_word(op_addi, 5, 6, 5'h18));
        drain();
    endtask

    // a back to back dependency stalls once and a distance two read uses the bypass
    task automatic dependent_ops();
        issue(i_word(op_addi, 1, 0, 5'd9));
        issue(r_word(fn_add, 2, 1, 1));
        issue(r_word(fn_sub, 3, 2, 1));
        issue(i_word(op_addi, 4, 0, 5'd3));
        issue(i_word(op_xori, 5, 0, 5'd6));
        issue(r_word(fn_add, 6, 4, 4));
        issue(r_word(fn_andn, 7, 0, 6));
        drain();
    endtask

    task automatic random_sequence();
        logic [15:0] f;
        int          k;
        for (int n = 0; n < 60; n++) begin
            f = next_rand();
            k = next_rand() % 6;
            if (k < 4) begin
                issue(r_word(k[1:0], f[2:0], f[5:3], f[8:6]));
            end else begin
                issue(i_word((k == 4) ? op_addi : op_xori, f[2:0], f[5:3], f[13:9]));
            end
        end
        drain();
    endtask

    task automatic nop_and_halt();
        issue(nop_instr);
        issue({op_halt, 11'd0});
        issue(i_word(op_addi, 1, 0, 5'd1));
        issue(r_word(fn_add, 2, 1, 1));
        drain();
        assert (halted) else report_fail("halted not set after HALT");
    endtask

    initial begin
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", limit_ns);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst     = 1'b1;
        pc_f    = '0;
        instr_f = nop_instr;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset_state();
        register_ops();
        immediate_ops();
        dependent_ops();
        random_sequence();
        nop_and_halt();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/cpu_pkg.sv
logic/de_bus.sv
logic/instruction_decoder.sv
logic/reg_file.sv
logic/decode_execute_latch.sv
logic/execute_unit.sv
logic/cpu_decode_execute.sv
sim/cpu_decode_execute_properties.sv
sim/cpu_decode_execute_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_decode_execute

sources:
  - logic/cpu_pkg.sv
  - logic/de_bus.sv
  - logic/instruction_decoder.sv
  - logic/reg_file.sv
  - logic/decode_execute_latch.sv
  - logic/execute_unit.sv
  - logic/cpu_decode_execute.sv
  - target: simulation
    files:
      - sim/cpu_decode_execute_properties.sv
      - sim/cpu_decode_execute_tb.sv
